/* divsqrt_top.f */
divsqrt_data_pkg.sv
divsqrt_ctrl_pkg.sv
divsqrt_pipe.sv
divsqrt_engine.sv
divsqrt_issue.sv
divsqrt_top.sv
divsqrt_props.sv
tb_divsqrt.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the divsqrt testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_divsqrt -f divsqrt_top.f \
  && ./obj_dir/Vtb_divsqrt | tee /dev/stderr | grep -q "Finished with no errors" \
  && echo "RESULT: PASS" \
  || { echo "RESULT: FAIL"; exit 1; }

/* tb_divsqrt.sv */
`timescale 1ns/100ps

module tb_divsqrt;

  localparam int unsigned InpRegs = 1;
  localparam int unsigned OutRegs = 1;
  localparam int unsigned Timeout = 2000;  // cycles per wait loop

  logic clk = 1'b0;
  logic rst_n_i, flush_i, in_valid_i, out_ready_i, mask_i;
  divsqrt_data_pkg::operand_t opa_i, opb_i, result_o;
  divsqrt_ctrl_pkg::op_e      op_i;
  divsqrt_data_pkg::tag_t     tag_i, tag_o;
  logic in_ready_o, div_zero_o, mask_o, out_valid_o, busy_o;

  logic [31:0] rng = 32'd81;  // xorshift state
  int unsigned cyc = 0;
  divsqrt_data_pkg::operand_t exp_res_q[$];  // model queues in input order
  logic                       exp_flag_q[$];
  divsqrt_data_pkg::tag_t     exp_tag_q[$];
  logic                       exp_mask_q[$];
  int unsigned                in_times[$];
  int unsigned                out_times[$];

  divsqrt_top #(.NumInpRegs(InpRegs), .NumOutRegs(OutRegs)) u_dut (
    .clk_i(clk), .rst_n_i(rst_n_i), .opa_i(opa_i), .opb_i(opb_i), .op_i(op_i),
    .tag_i(tag_i), .mask_i(mask_i), .in_valid_i(in_valid_i), .flush_i(flush_i),
    .out_ready_i(out_ready_i), .in_ready_o(in_ready_o), .result_o(result_o),
    .div_zero_o(div_zero_o), .tag_o(tag_o), .mask_o(mask_o),
    .out_valid_o(out_valid_o), .busy_o(busy_o)
  );

  always #10 clk = ~clk;                 // 20 ns period
  always @(posedge clk) cyc <= cyc + 1;  // edge counter for latency

  // --------------------
  // helpers
  // --------------------
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // floor of the root by binary search
  function automatic divsqrt_data_pkg::operand_t model_sqrt(divsqrt_data_pkg::operand_t a);
    longint unsigned lo, hi, mid;
    lo = 0;
    hi = 65535;
    while (lo < hi) begin
      mid = (lo + hi + 1) / 2;
      if (mid * mid <= longint'(a)) lo = mid;
      else hi = mid - 1;
    end
    return divsqrt_data_pkg::operand_t'(lo);
  endfunction

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_result(string name, divsqrt_data_pkg::operand_t got,
                              divsqrt_data_pkg::operand_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_tag(string name, divsqrt_data_pkg::tag_t got, divsqrt_data_pkg::tag_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_count(string name, int unsigned got, int unsigned exp);
    if (got != exp) begin
      stop_on_error($sformatf("Mismatch %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // --------------------
  // monitor sampled mid-cycle where everything is settled
  // --------------------
  always @(negedge clk) begin
    if (rst_n_i && !flush_i) begin
      if (in_valid_i && in_ready_o) begin  // transfer on the coming edge
        in_times.push_back(cyc);
        exp_tag_q.push_back(tag_i);
        exp_mask_q.push_back(mask_i);
        if (op_i == divsqrt_ctrl_pkg::OP_SQRT) begin
          exp_res_q.push_back(model_sqrt(opa_i));
          exp_flag_q.push_back(1'b0);
        end else if (opb_i == '0) begin
          exp_res_q.push_back('1);                   // zero divisor
          exp_flag_q.push_back(1'b1);
        end else begin
          exp_res_q.push_back(opa_i / opb_i);
          exp_flag_q.push_back(1'b0);
        end
      end
      if (out_valid_o && out_ready_i) begin
        if (exp_res_q.size() == 0) stop_on_error("output appeared with no operation pending");
        out_times.push_back(cyc);
        check_result("result_o", result_o, exp_res_q.pop_front());
        check_flag("div_zero_o", div_zero_o, exp_flag_q.pop_front());
        check_tag("tag_o", tag_o, exp_tag_q.pop_front());
        check_flag("mask_o", mask_o, exp_mask_q.pop_front());
      end
    end
  end

  // --------------------
  // stimulus tasks
  // --------------------
  task automatic drive_op(logic sqrt, divsqrt_data_pkg::operand_t a,
                          divsqrt_data_pkg::operand_t b);
    logic [31:0] r;
    r = next_rand();
    op_i       <= divsqrt_ctrl_pkg::op_e'(sqrt);
    opa_i      <= a;
    opb_i      <= b;
    tag_i      <= r[3:0];
    mask_i     <= r[4];
    in_valid_i <= 1'b1;
  endtask

  // one random operation with mode 0 div, 1 sqrt, 2 mixed
  task automatic drive_random(int mode);
    logic [31:0] r, a, b;
    logic        sqrt;
    r = next_rand();
    a = next_rand();
    b = next_rand() >> (r[12:8]);          // spread divisor sizes
    sqrt = (mode == 2) ? r[0] : (mode == 1);
    if (!sqrt && r[7:5] == 3'd0) b = '0;   // zero divisor now and then
    if (sqrt && r[7:5] == 3'd1) a = '0;
    if (sqrt && r[7:5] == 3'd2) a = '1;
    drive_op(sqrt, a, b);
  endtask

  task automatic random_phase(int cycles, int mode, logic backpressure);
    logic [31:0] r;
    logic        ready;
    int unsigned run;
    ready = 1'b1;
    run   = 0;
    repeat (cycles) begin
      @(posedge clk);
      r = next_rand();
      drive_random(mode);
      in_valid_i <= (r[3:0] < 4'd11);   // mostly valid
      if (run == 0) begin
        ready = backpressure ? (r[9:0] % 10 < 7) : 1'b1;
        run   = r[21:16] + 1;           // stalls long enough to park a result in hold
      end
      run--;
      out_ready_i <= ready;
    end
  endtask

  task automatic drain();
    int unsigned n;
    @(posedge clk);
    in_valid_i  <= 1'b0;
    out_ready_i <= 1'b1;
    n = 0;
    while (exp_res_q.size() != 0 || busy_o) begin
      @(negedge clk);
      n++;
      if (n > Timeout) stop_on_error("pending results never came out during drain");
    end
  endtask

  // hold valid until the monitor sees the transfer
  task automatic wait_accept();
    int unsigned n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > Timeout) stop_on_error("operation was never accepted");
    end while (!(in_valid_i && in_ready_o));
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    int unsigned steps[6];
    int unsigned n;
    rst_n_i     = 1'b0;
    flush_i     = 1'b0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    opa_i       = '0;
    opb_i       = '0;
    op_i        = divsqrt_ctrl_pkg::OP_DIV;
    tag_i       = '0;
    mask_i      = 1'b0;
    repeat (4) @(posedge clk);
    rst_n_i <= 1'b1;
    @(negedge clk);
    check_flag("out_valid_o", out_valid_o, 1'b0);
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("in_ready_o", in_ready_o, 1'b1);

    random_phase(3000, 0, 1'b0);   // divisions
    drain();
    random_phase(2000, 1, 1'b0);   // square roots
    drain();
    random_phase(4000, 2, 1'b1);   // back-pressure exercises the hold path
    drain();

    // back-to-back stream with ready high
    in_times.delete();
    out_times.delete();
    for (int i = 0; i < 6; i++) begin
      @(posedge clk);
      drive_random(2);
      steps[i] = (next_rand() & 1) ? divsqrt_ctrl_pkg::SQRT_STEPS : divsqrt_ctrl_pkg::DIV_STEPS;
      op_i <= (steps[i] == divsqrt_ctrl_pkg::SQRT_STEPS) ? divsqrt_ctrl_pkg::OP_SQRT
                                                         : divsqrt_ctrl_pkg::OP_DIV;
      wait_accept();
    end
    @(posedge clk);
    in_valid_i <= 1'b0;
    n = 0;
    while (out_times.size() < 6) begin
      @(negedge clk);
      n++;
      if (n > Timeout) stop_on_error("stream results did not all arrive");
    end
    check_count("latency", out_times[0] - in_times[0], InpRegs + steps[0] + OutRegs);
    for (int i = 1; i < 6; i++) begin
      check_count("issue gap", out_times[i] - out_times[i-1], steps[i]);  // no idle cycle
    end

    // flush in mid-operation
    for (int i = 0; i < 2; i++) begin
      @(posedge clk);
      drive_random(0);
      wait_accept();
    end
    @(posedge clk);
    in_valid_i <= 1'b0;
    repeat (10) @(posedge clk);
    out_ready_i <= 1'b0;
    flush_i     <= 1'b1;
    @(negedge clk);
    exp_res_q.delete();   // in-flight work is lost
    exp_flag_q.delete();
    exp_tag_q.delete();
    exp_mask_q.delete();
    @(posedge clk);
    flush_i     <= 1'b0;
    out_ready_i <= 1'b1;
    @(negedge clk);
    check_flag("busy_o", busy_o, 1'b0);
    repeat (40) begin
      @(negedge clk);
      if (out_valid_o) stop_on_error("output appeared after flush");
    end
    random_phase(2000, 2, 1'b1);   // still correct after flush
    drain();

    $display("Finished with no errors");
    $finish;
  end

endmodule

/* divsqrt_props.sv */
`timescale 1ns/100ps

module divsqrt_props (
  input logic                           clk_i,
  input logic                           rst_n_i,
  input logic                           flush_i,
  input logic                           out_valid_o,
  input logic                           out_ready_i,
  input divsqrt_data_pkg::operand_t     result_o,
  input logic                           div_zero_o,
  input divsqrt_data_pkg::tag_t         tag_o,
  input logic                           mask_o,
  input logic                           busy_o,
  input divsqrt_ctrl_pkg::issue_state_e state_i,     // issue fsm state
  input logic                           iss_ready_i  // output pipe takes issue result
);

  // --------------------
  // output stall
  // --------------------
  // a stalled result may not change or vanish
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=>
      out_valid_o && $stable(result_o) && $stable(div_zero_o) &&
      $stable(tag_o) && $stable(mask_o))
    else $error("output changed while stalled");

  // everything drains on flush
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !busy_o)
    else $error("busy still high after flush");

  // --------------------
  // hold state
  // --------------------
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    state_i == divsqrt_ctrl_pkg::ISSUE_HOLD && !iss_ready_i && !flush_i |=>
      state_i == divsqrt_ctrl_pkg::ISSUE_HOLD)  // parked result stays parked
    else $error("issue fsm left hold without a transfer");

endmodule

bind divsqrt_top divsqrt_props u_props (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .flush_i     (flush_i),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .result_o    (result_o),
  .div_zero_o  (div_zero_o),
  .tag_o       (tag_o),
  .mask_o      (mask_o),
  .busy_o      (busy_o),
  .state_i     (u_issue.state_q),
  .iss_ready_i (iss_ready)
);

/* divsqrt_top.sv */
`timescale 1ns/100ps

module divsqrt_top #(
  parameter int unsigned NumInpRegs = 1,
  parameter int unsigned NumOutRegs = 1
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  divsqrt_data_pkg::operand_t opa_i,
  input  divsqrt_data_pkg::operand_t opb_i,
  input  divsqrt_ctrl_pkg::op_e      op_i,
  input  divsqrt_data_pkg::tag_t     tag_i,
  input  logic                       mask_i,
  input  logic                       in_valid_i,
  input  logic                       flush_i,
  input  logic                       out_ready_i,
  output logic                       in_ready_o,
  output divsqrt_data_pkg::operand_t result_o,
  output logic                       div_zero_o,
  output divsqrt_data_pkg::tag_t     tag_o,
  output logic                       mask_o,
  output logic                       out_valid_o,
  output logic                       busy_o
);

  // input pipe side
  divsqrt_data_pkg::in_payload_t  in_payload, inp_payload_q;
  logic                           inp_valid, inp_ready, in_pipe_busy;
  divsqrt_data_pkg::operand_t     inp_opa, inp_opb;
  logic                           inp_op_bit;
  divsqrt_ctrl_pkg::op_e          inp_op;
  divsqrt_data_pkg::tag_t         inp_tag;
  logic                           inp_mask;
  // engine handshake
  logic                           eng_start, eng_done, eng_div_zero;
  divsqrt_data_pkg::operand_t     eng_result;
  // issue to output pipe
  logic                           iss_valid, iss_ready, iss_div_zero, iss_mask, iss_busy;
  divsqrt_data_pkg::operand_t     iss_result;
  divsqrt_data_pkg::tag_t         iss_tag;
  divsqrt_data_pkg::out_payload_t iss_payload, out_payload_q;
  logic                           out_pipe_busy;

  // --------------------
  // input pipeline
  // --------------------
  assign in_payload = {opa_i, opb_i, op_i, tag_i, mask_i};

  divsqrt_pipe #(
    .Width   (divsqrt_data_pkg::IN_PAYLOAD_WIDTH),
    .NumRegs (NumInpRegs)
  ) u_in_pipe (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_data_i   (in_payload),
    .out_valid_o (inp_valid),
    .out_ready_i (inp_ready),
    .out_data_o  (inp_payload_q),
    .busy_o      (in_pipe_busy)
  );

  assign {inp_opa, inp_opb, inp_op_bit, inp_tag, inp_mask} = inp_payload_q;
  assign inp_op = divsqrt_ctrl_pkg::op_e'(inp_op_bit);

  divsqrt_issue u_issue (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (inp_valid),
    .in_ready_o  (inp_ready),
    .tag_i       (inp_tag),
    .mask_i      (inp_mask),
    .start_o     (eng_start),
    .done_i      (eng_done),
    .result_i    (eng_result),
    .div_zero_i  (eng_div_zero),
    .out_valid_o (iss_valid),
    .out_ready_i (iss_ready),
    .result_o    (iss_result),
    .div_zero_o  (iss_div_zero),
    .tag_o       (iss_tag),
    .mask_o      (iss_mask),
    .busy_o      (iss_busy)
  );

  // operands are taken straight from the input pipe head at start
  divsqrt_engine u_engine (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .start_i    (eng_start),
    .op_i       (inp_op),
    .opa_i      (inp_opa),
    .opb_i      (inp_opb),
    .done_o     (eng_done),
    .result_o   (eng_result),
    .div_zero_o (eng_div_zero)
  );

  // --------------------
  // output pipeline
  // --------------------
  assign iss_payload = {iss_result, iss_div_zero, iss_tag, iss_mask};

  divsqrt_pipe #(
    .Width   (divsqrt_data_pkg::OUT_PAYLOAD_WIDTH),
    .NumRegs (NumOutRegs)
  ) u_out_pipe (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (iss_valid),
    .in_ready_o  (iss_ready),
    .in_data_i   (iss_payload),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_payload_q),
    .busy_o      (out_pipe_busy)
  );

  assign {result_o, div_zero_o, tag_o, mask_o} = out_payload_q;
  assign busy_o = in_pipe_busy | iss_busy | out_pipe_busy;  // anything in flight

endmodule

/* divsqrt_issue.sv */
`timescale 1ns/100ps

module divsqrt_issue (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       flush_i,
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  input  divsqrt_data_pkg::tag_t     tag_i,
  input  logic                       mask_i,
  output logic                       start_o,
  input  logic                       done_i,
  input  divsqrt_data_pkg::operand_t result_i,
  input  logic                       div_zero_i,
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  output divsqrt_data_pkg::operand_t result_o,
  output logic                       div_zero_o,
  output divsqrt_data_pkg::tag_t     tag_o,
  output logic                       mask_o,
  output logic                       busy_o
);

  divsqrt_ctrl_pkg::issue_state_e state_q, state_d;
  logic                       in_ready;       // fsm may take a new op
  logic                       out_valid;      // result offered downstream
  logic                       hold_load;      // park engine result
  logic                       data_is_held;   // output comes from hold register
  divsqrt_data_pkg::tag_t     tag_q;
  logic                       mask_q;
  divsqrt_data_pkg::operand_t held_result_q;
  logic                       held_div_zero_q;

  // --------------------
  // issue fsm
  // --------------------
  always_comb begin
    in_ready     = 1'b0;
    out_valid    = 1'b0;
    hold_load    = 1'b0;
    data_is_held = 1'b0;
    state_d      = state_q;

    unique case (state_q)
      divsqrt_ctrl_pkg::ISSUE_IDLE: begin
        in_ready = 1'b1;
        if (in_valid_i) state_d = divsqrt_ctrl_pkg::ISSUE_BUSY;
      end
      divsqrt_ctrl_pkg::ISSUE_BUSY: begin
        if (done_i) begin
          out_valid = 1'b1;                          // offer in the done cycle itself
          if (out_ready_i) begin
            in_ready = 1'b1;                         // back-to-back issue
            state_d  = in_valid_i ? divsqrt_ctrl_pkg::ISSUE_BUSY :
                                    divsqrt_ctrl_pkg::ISSUE_IDLE;
          end else begin
            hold_load = 1'b1;
            state_d   = divsqrt_ctrl_pkg::ISSUE_HOLD;
          end
        end
      end
      divsqrt_ctrl_pkg::ISSUE_HOLD: begin
        data_is_held = 1'b1;
        out_valid    = 1'b1;                         // keep offering until taken
        if (out_ready_i) begin
          in_ready = 1'b1;
          state_d  = in_valid_i ? divsqrt_ctrl_pkg::ISSUE_BUSY :
                                  divsqrt_ctrl_pkg::ISSUE_IDLE;
        end
      end
      default: state_d = divsqrt_ctrl_pkg::ISSUE_IDLE;
    endcase

    // flush wins over everything
    if (flush_i) begin
      in_ready  = 1'b0;
      out_valid = 1'b0;
      state_d   = divsqrt_ctrl_pkg::ISSUE_IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= divsqrt_ctrl_pkg::ISSUE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign in_ready_o = in_ready;
  assign start_o    = in_valid_i & in_ready;  // accept == start

  // tag and mask ride beside the engine
  always_ff @(posedge clk_i) begin
    if (start_o) begin
      tag_q  <= tag_i;
      mask_q <= mask_i;
    end
  end

  // hold register loads when done meets a stalled output
  always_ff @(posedge clk_i) begin
    if (hold_load) begin
      held_result_q   <= result_i;
      held_div_zero_q <= div_zero_i;
    end
  end

  // --------------------
  // output select
  // --------------------
  assign result_o    = data_is_held ? held_result_q : result_i;
  assign div_zero_o  = data_is_held ? held_div_zero_q : div_zero_i;
  assign tag_o       = tag_q;
  assign mask_o      = mask_q;
  assign out_valid_o = out_valid;
  assign busy_o      = (state_q != divsqrt_ctrl_pkg::ISSUE_IDLE);  // busy or hold

endmodule

/* divsqrt_engine.sv */
`timescale 1ns/100ps

module divsqrt_engine (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       flush_i,
  input  logic                       start_i,
  input  divsqrt_ctrl_pkg::op_e      op_i,
  input  divsqrt_data_pkg::operand_t opa_i,
  input  divsqrt_data_pkg::operand_t opb_i,
  output logic                       done_o,
  output divsqrt_data_pkg::operand_t result_o,
  output logic                       div_zero_o
);

  localparam int unsigned Width     = divsqrt_data_pkg::OPERAND_WIDTH;
  localparam int unsigned RootWidth = Width / 2;
  localparam int unsigned CntWidth  = $clog2(divsqrt_ctrl_pkg::DIV_STEPS);

  divsqrt_ctrl_pkg::op_e      op_q, op_src;
  divsqrt_data_pkg::operand_t rem_q, rem_src, rem_d;  // partial remainder
  divsqrt_data_pkg::operand_t quo_q, quo_src, quo_d;  // dividend/radicand shifting out
  divsqrt_data_pkg::operand_t dvs_q, dvs_src;         // divisor
  logic [RootWidth-1:0]       root_q, root_src, root_d;
  logic [CntWidth-1:0]        cnt_q, cnt_src, last_step;
  logic                       running_q, done_q;
  logic                       step_en;
  logic [Width:0]             minuend, subtrahend, diff;  // one extra bit for the sign
  logic                       take;                       // difference not negative

  // --------------------
  // step source
  // --------------------
  // on start the first step runs straight from the new operands, so the
  // last one lands exactly DIV_STEPS / SQRT_STEPS cycles after start
  always_comb begin
    if (start_i) begin
      op_src   = op_i;
      rem_src  = '0;
      quo_src  = opa_i;
      dvs_src  = opb_i;
      root_src = '0;
      cnt_src  = '0;
    end else begin
      op_src   = op_q;
      rem_src  = rem_q;
      quo_src  = quo_q;
      dvs_src  = dvs_q;
      root_src = root_q;
      cnt_src  = cnt_q;
    end
  end

  assign step_en   = start_i | running_q;
  assign last_step = (op_src == divsqrt_ctrl_pkg::OP_DIV) ?
                     CntWidth'(divsqrt_ctrl_pkg::DIV_STEPS - 1) :
                     CntWidth'(divsqrt_ctrl_pkg::SQRT_STEPS - 1);

  // --------------------
  // shared subtractor
  // --------------------
  always_comb begin
    if (op_src == divsqrt_ctrl_pkg::OP_DIV) begin
      minuend    = {rem_src, quo_src[Width-1]};           // bring down one dividend bit
      subtrahend = {1'b0, dvs_src};
    end else begin
      minuend    = {1'b0, rem_src[Width-3:0], quo_src[Width-1:Width-2]};  // two radicand bits
      subtrahend = {1'b0, {(Width-RootWidth-2){1'b0}}, root_src, 2'b01};  // 4*root + 1
    end
    diff = minuend - subtrahend;
    take = ~diff[Width];
    rem_d = take ? diff[Width-1:0] : minuend[Width-1:0];   // restore on a negative trial
    if (op_src == divsqrt_ctrl_pkg::OP_DIV) begin
      quo_d = {quo_src[Width-2:0], take};                   // quotient bit enters at lsb
    end else begin
      quo_d = {quo_src[Width-3:0], 2'b00};
    end
    root_d = {root_src[RootWidth-2:0], take};               // only meaningful for sqrt
  end

  // --------------------
  // control
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      running_q <= 1'b0;
      done_q    <= 1'b0;
      cnt_q     <= '0;
    end else if (flush_i) begin
      running_q <= 1'b0;  // abort, nothing comes out
      done_q    <= 1'b0;
    end else if (step_en) begin
      if (cnt_src == last_step) begin
        running_q <= 1'b0;
        done_q    <= 1'b1;
      end else begin
        running_q <= 1'b1;
        done_q    <= 1'b0;
        cnt_q     <= cnt_src + 1'b1;
      end
    end else begin
      done_q <= 1'b0;      // single-cycle pulse
    end
  end

  // working registers freeze once the last step is done
  always_ff @(posedge clk_i) begin
    if (step_en) begin
      op_q   <= op_src;
      rem_q  <= rem_d;
      quo_q  <= quo_d;
      dvs_q  <= dvs_src;
      root_q <= root_d;
    end
  end

  assign done_o     = done_q;
  assign result_o   = (op_q == divsqrt_ctrl_pkg::OP_DIV) ? quo_q :
                      {{(Width-RootWidth){1'b0}}, root_q};
  // zero divisor leaves all trials positive, so the quotient is already all ones
  assign div_zero_o = (op_q == divsqrt_ctrl_pkg::OP_DIV) & (dvs_q == '0);

endmodule

/* divsqrt_pipe.sv */
`timescale 1ns/100ps

module divsqrt_pipe #(
  parameter int unsigned Width   = 8,
  parameter int unsigned NumRegs = 1
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             flush_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  logic [Width-1:0] in_data_i,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output logic [Width-1:0] out_data_o,
  output logic             busy_o
);

  // index k is the value after k register stages, index 0 is the pipe input
  logic             valid      [0:NumRegs];
  logic             ready      [0:NumRegs];  // combinational, flows backwards
  logic [Width-1:0] data       [0:NumRegs];
  logic             busy_chain [0:NumRegs];  // running OR of stage valids

  assign valid[0]      = in_valid_i;
  assign data[0]       = in_data_i;
  assign busy_chain[0] = 1'b0;               // the input itself is not held here
  assign in_ready_o    = ready[0];

  for (genvar i = 0; i < NumRegs; i++) begin : gen_stage
    logic load;  // an item moves into stage i+1

    // stage can advance if next one takes it or next one only holds a bubble
    assign ready[i] = ready[i+1] | ~valid[i+1];
    assign load     = ready[i] & valid[i];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        valid[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid[i+1] <= 1'b0;      // drop whatever is in flight
      end else if (ready[i]) begin
        valid[i+1] <= valid[i];
      end
    end

    // payload only moves with a real item
    always_ff @(posedge clk_i) begin
      if (load) begin
        data[i+1] <= data[i];
      end
    end

    assign busy_chain[i+1] = busy_chain[i] | valid[i+1];
  end

  // last stage talks to downstream
  assign ready[NumRegs] = out_ready_i;
  assign out_valid_o    = valid[NumRegs];
  assign out_data_o     = data[NumRegs];
  assign busy_o         = busy_chain[NumRegs];

endmodule

/* divsqrt_ctrl_pkg.sv */
package divsqrt_ctrl_pkg;

  // operation select carried with every request
  typedef enum logic {
    OP_DIV  = 1'b0,  // integer quotient opa / opb
    OP_SQRT = 1'b1   // integer root of opa, opb ignored
  } op_e;

  // issue controller states
  typedef enum logic [1:0] {
    ISSUE_IDLE = 2'd0,  // waiting for work
    ISSUE_BUSY = 2'd1,  // engine iterating
    ISSUE_HOLD = 2'd2   // result parked, downstream stalled
  } issue_state_e;

  // iteration counts of the engine
  localparam int unsigned DIV_STEPS  = 32;  // one quotient bit per cycle
  localparam int unsigned SQRT_STEPS = 16;  // one root bit per cycle

endpackage

/* divsqrt_data_pkg.sv */
package divsqrt_data_pkg;

  // --------------------
  // basic widths
  // --------------------
  localparam int unsigned OPERAND_WIDTH = 32;  // dividend, divisor, radicand and result
  localparam int unsigned TAG_WIDTH     = 4;   // caller tag, returned untouched

  typedef logic [OPERAND_WIDTH-1:0] operand_t;  // one operand or one result
  typedef logic [TAG_WIDTH-1:0]     tag_t;      // transaction tag

  // --------------------
  // pipeline payloads
  // --------------------
  // input side carries opa, opb, op bit, tag and mask (msb first)
  localparam int unsigned IN_PAYLOAD_WIDTH = 2 * OPERAND_WIDTH  // both operands
                                           + 1                  // operation select
                                           + TAG_WIDTH
                                           + 1;                 // mask

  // output side carries result, div-by-zero flag, tag and mask (msb first)
  localparam int unsigned OUT_PAYLOAD_WIDTH = OPERAND_WIDTH
                                            + 1                 // div-by-zero
                                            + TAG_WIDTH
                                            + 1;                // mask

  typedef logic [IN_PAYLOAD_WIDTH-1:0]  in_payload_t;   // 70 bits
  typedef logic [OUT_PAYLOAD_WIDTH-1:0] out_payload_t;  // 38 bits

endpackage
